//--- soc_pkg.sv
// soc package
// shared widths, PerInt op codes, slave indices, address map,
// device ids and reset counter constants
`default_nettype none

package soc_pkg;

	// data and address widths
	localparam int unsigned ARCHBITSZ = 32;
	localparam int unsigned ADDRBITSZ = 30;

	typedef logic [ARCHBITSZ-1:0] word_t;
	typedef logic [ADDRBITSZ-1:0] waddr_t;
	typedef logic [ARCHBITSZ/8-1:0] bsel_t;

	// PerInt operations
	typedef logic [1:0] op_t;
	localparam op_t OP_NOOP = 2'd0;
	localparam op_t OP_WRITE = 2'd1;
	localparam op_t OP_READ = 2'd2;
	localparam op_t OP_SWAP = 2'd3;

	// slave indices with the default slave last
	typedef logic [1:0] slave_idx_t;
	localparam slave_idx_t S_RAM = 2'd0;
	localparam slave_idx_t S_DEVTBL = 2'd1;
	localparam slave_idx_t S_INVALID = 2'd2;
	localparam int unsigned SLAVECOUNT = 3;

	// address map in words
	localparam int unsigned RAM_BASE = 0;
	localparam int unsigned RAM_MAPSZ = 1024;
	localparam int unsigned DEVTBL_BASE = 1024;
	localparam int unsigned DEVTBL_MAPSZ = 64;
	localparam int unsigned INVALID_MAPSZ = 1024;

	// ids reported through the device table
	localparam word_t DEV_ID_RAM = 32'd1;
	localparam word_t DEV_ID_DEVTBL = 32'd7;
	localparam word_t DEV_ID_INVALID = 32'd0;

	// reset sequencing
	localparam int unsigned RST_CNTR_BITSZ = 4;
	typedef logic [RST_CNTR_BITSZ-1:0] rst_cntr_t;
	localparam rst_cntr_t RST_CNTR_LOAD = '1;

endpackage

`default_nettype wire

//--- pi1_if.sv
// PerInt slave-side bus
// carries one request from the interconnect to a slave and the
// read data and ready level back
`timescale 1ns/1ps
`default_nettype none

interface pi1_if;

	soc_pkg::op_t op;
	soc_pkg::waddr_t addr;
	soc_pkg::word_t wdata;
	soc_pkg::bsel_t sel;
	// response side
	soc_pkg::word_t rdata;
	logic rdy;

	modport master (
		 output op
		,output addr
		,output wdata
		,output sel
		,input rdata
		,input rdy
	);

	modport slave (
		 input op
		,input addr
		,input wdata
		,input sel
		,output rdata
		,output rdy
	);

endinterface

`default_nettype wire

//--- reset_ctrl.sv
// reset controller
// stretches rst_p with a down counter, restarts it on a software warm
// reset and latches a software power-off until the next rst_p
`timescale 1ns/1ps
`default_nettype none

module reset_ctrl (
	 input wire clk120mhz
	,input wire rst_p
	,input wire dt_rst0_i
	,input wire dt_rst1_i
	,output logic sys_rst_o
);

	logic warm_rst;
	logic pwr_off;
	logic pwr_off_q;
	soc_pkg::rst_cntr_t rst_cntr;

	// rst1 alone is a warm reset, rst0 alone a power-off
	// both set used to mean a cold reset, which has no meaning here
	assign warm_rst = dt_rst1_i & ~dt_rst0_i;
	assign pwr_off = dt_rst0_i & ~dt_rst1_i;

	always_ff @(posedge clk120mhz) begin
		if (rst_p || warm_rst) begin
			rst_cntr <= soc_pkg::RST_CNTR_LOAD;
		end else if (rst_cntr != '0) begin
			rst_cntr <= rst_cntr - soc_pkg::rst_cntr_t'(1);
		end
	end

	// sticky until a board reset
	always_ff @(posedge clk120mhz) begin
		if (rst_p) begin
			pwr_off_q <= 1'b0;
		end else if (pwr_off) begin
			pwr_off_q <= 1'b1;
		end
	end

	assign sys_rst_o = (rst_cntr != '0) || pwr_off_q;

endmodule

`default_nettype wire

//--- pi1_xbar.sv
// PerInt interconnect for a single master
// decodes the word address to the RAM, the device table or the
// built-in default slave, and returns read data a cycle later
`timescale 1ns/1ps
`default_nettype none

module pi1_xbar (
	 input wire clk120mhz
	,input wire sys_rst_i
	,input wire soc_pkg::op_t m_op_i
	,input wire soc_pkg::waddr_t m_addr_i
	,input wire soc_pkg::word_t m_data_i
	,input wire soc_pkg::bsel_t m_sel_i
	,output soc_pkg::word_t m_data_o
	,output logic m_rdy_o
	,pi1_if.master ram_bus
	,pi1_if.master dt_bus
);

	localparam soc_pkg::waddr_t RAM_BASE_A = soc_pkg::waddr_t'(soc_pkg::RAM_BASE);
	localparam soc_pkg::waddr_t RAM_SIZE_A = soc_pkg::waddr_t'(soc_pkg::RAM_MAPSZ);
	localparam soc_pkg::waddr_t DT_BASE_A = soc_pkg::waddr_t'(soc_pkg::DEVTBL_BASE);
	localparam soc_pkg::waddr_t DT_SIZE_A = soc_pkg::waddr_t'(soc_pkg::DEVTBL_MAPSZ);

	soc_pkg::waddr_t ram_off;
	soc_pkg::waddr_t dt_off;
	soc_pkg::slave_idx_t req_idx;
	soc_pkg::slave_idx_t resp_idx;
	logic req_rdy;
	logic accept;
	logic is_read;

	// an address below a base wraps to a large offset and misses
	assign ram_off = m_addr_i - RAM_BASE_A;
	assign dt_off = m_addr_i - DT_BASE_A;

	always_comb begin
		if (ram_off < RAM_SIZE_A) begin
			req_idx = soc_pkg::S_RAM;
		end else if (dt_off < DT_SIZE_A) begin
			req_idx = soc_pkg::S_DEVTBL;
		end else begin
			req_idx = soc_pkg::S_INVALID;
		end
	end

	// only the selected slave sees an operation
	assign ram_bus.op = (req_idx == soc_pkg::S_RAM) ? m_op_i : soc_pkg::OP_NOOP;
	assign ram_bus.addr = ram_off;
	assign ram_bus.wdata = m_data_i;
	assign ram_bus.sel = m_sel_i;

	assign dt_bus.op = (req_idx == soc_pkg::S_DEVTBL) ? m_op_i : soc_pkg::OP_NOOP;
	assign dt_bus.addr = dt_off;
	assign dt_bus.wdata = m_data_i;
	assign dt_bus.sel = m_sel_i;

	always_comb begin
		case (req_idx)
			soc_pkg::S_RAM: req_rdy = ram_bus.rdy;
			soc_pkg::S_DEVTBL: req_rdy = dt_bus.rdy;
			// default slave takes anything and drops writes
			default: req_rdy = 1'b1;
		endcase
	end

	assign m_rdy_o = req_rdy & ~sys_rst_i;
	assign accept = (m_op_i != soc_pkg::OP_NOOP) && m_rdy_o;
	assign is_read = (m_op_i == soc_pkg::OP_READ) || (m_op_i == soc_pkg::OP_SWAP);

	// which slave owes the pending read data
	always_ff @(posedge clk120mhz) begin
		if (sys_rst_i) begin
			resp_idx <= soc_pkg::S_INVALID;
		end else if (accept && is_read) begin
			resp_idx <= req_idx;
		end
	end

	always_comb begin
		case (resp_idx)
			soc_pkg::S_RAM: m_data_o = ram_bus.rdata;
			soc_pkg::S_DEVTBL: m_data_o = dt_bus.rdata;
			default: m_data_o = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- ram_slave.sv
// word RAM slave
// byte-select writes, single-cycle reads and atomic swaps
`timescale 1ns/1ps
`default_nettype none

module ram_slave #(
	parameter int unsigned RAM_WORDS = 1024
) (
	 input wire clk120mhz
	,input wire sys_rst_i
	,pi1_if.slave bus
);

	localparam int unsigned IDX_BITS = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;
	localparam int unsigned BYTES = soc_pkg::ARCHBITSZ / 8;

	soc_pkg::word_t mem [RAM_WORDS];
	soc_pkg::word_t rdata_q;
	logic [IDX_BITS-1:0] idx;
	logic accept;
	logic do_write;
	logic do_read;

	// upper offset bits alias when the RAM is smaller than its map
	assign idx = bus.addr[IDX_BITS-1:0];

	assign bus.rdy = ~sys_rst_i;
	assign accept = (bus.op != soc_pkg::OP_NOOP) && bus.rdy;
	assign do_write = accept && (bus.op == soc_pkg::OP_WRITE || bus.op == soc_pkg::OP_SWAP);
	assign do_read = accept && (bus.op == soc_pkg::OP_READ || bus.op == soc_pkg::OP_SWAP);

	always_ff @(posedge clk120mhz) begin
		if (do_write) begin
			for (int b = 0; b < BYTES; b++) begin
				if (bus.sel[b]) begin
					mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
				end
			end
		end
	end

	// a swap returns the word as it was before this access
	always_ff @(posedge clk120mhz) begin
		if (do_read) begin
			rdata_q <= mem[idx];
		end
	end

	assign bus.rdata = rdata_q;

endmodule

`default_nettype wire

//--- dev_table.sv
// device table
// word 0 holds the slave count, word 1 the software reset levels,
// then an id word and a map size word per slave
`timescale 1ns/1ps
`default_nettype none

module dev_table (
	 input wire clk120mhz
	,input wire sys_rst_i
	,pi1_if.slave bus
	,output logic dt_rst0_o
	,output logic dt_rst1_o
);

	localparam int unsigned WORD_BITS = $clog2(soc_pkg::DEVTBL_MAPSZ);
	localparam logic [WORD_BITS-1:0] W_COUNT = WORD_BITS'(0);
	localparam logic [WORD_BITS-1:0] W_CTRL = WORD_BITS'(1);
	localparam logic [WORD_BITS-1:0] W_FIRST = WORD_BITS'(2);
	localparam logic [WORD_BITS-1:0] W_END = WORD_BITS'(2 + 2 * soc_pkg::SLAVECOUNT);
	// no slave raises interrupts in this system
	localparam logic [soc_pkg::SLAVECOUNT-1:0] DEV_USEINTR = '0;

	logic [WORD_BITS-1:0] word;
	logic [WORD_BITS-1:0] entry_word;
	soc_pkg::slave_idx_t entry;
	soc_pkg::word_t entry_mapsz;
	soc_pkg::word_t rd_word;
	soc_pkg::word_t rdata_q;
	logic accept;
	logic do_write;
	logic do_read;

	function automatic soc_pkg::word_t dev_id(input soc_pkg::slave_idx_t k);
		case (k)
			soc_pkg::S_RAM: return soc_pkg::DEV_ID_RAM;
			soc_pkg::S_DEVTBL: return soc_pkg::DEV_ID_DEVTBL;
			default: return soc_pkg::DEV_ID_INVALID;
		endcase
	endfunction

	function automatic soc_pkg::word_t dev_mapsz(input soc_pkg::slave_idx_t k);
		case (k)
			soc_pkg::S_RAM: return soc_pkg::word_t'(soc_pkg::RAM_MAPSZ);
			soc_pkg::S_DEVTBL: return soc_pkg::word_t'(soc_pkg::DEVTBL_MAPSZ);
			default: return soc_pkg::word_t'(soc_pkg::INVALID_MAPSZ);
		endcase
	endfunction

	assign word = bus.addr[WORD_BITS-1:0];
	assign entry_word = (word - W_FIRST) >> 1;
	assign entry = soc_pkg::slave_idx_t'(entry_word);
	assign entry_mapsz = dev_mapsz(entry);

	assign bus.rdy = ~sys_rst_i;
	assign accept = (bus.op != soc_pkg::OP_NOOP) && bus.rdy;
	assign do_write = accept && (bus.op == soc_pkg::OP_WRITE || bus.op == soc_pkg::OP_SWAP);
	assign do_read = accept && (bus.op == soc_pkg::OP_READ || bus.op == soc_pkg::OP_SWAP);

	always_comb begin
		if (word == W_COUNT) begin
			rd_word = soc_pkg::word_t'(soc_pkg::SLAVECOUNT);
		end else if (word == W_CTRL) begin
			rd_word = {{(soc_pkg::ARCHBITSZ-2){1'b0}}, dt_rst1_o, dt_rst0_o};
		end else if (word < W_END) begin
			// odd words carry the map size, bit 31 the interrupt-use flag
			if (word[0]) begin
				rd_word = {DEV_USEINTR[entry], entry_mapsz[soc_pkg::ARCHBITSZ-2:0]};
			end else begin
				rd_word = dev_id(entry);
			end
		end else begin
			rd_word = '0;
		end
	end

	// the reset levels clear as soon as the system reset they cause arrives
	always_ff @(posedge clk120mhz) begin
		if (sys_rst_i) begin
			dt_rst0_o <= 1'b0;
			dt_rst1_o <= 1'b0;
		end else if (do_write && word == W_CTRL) begin
			dt_rst0_o <= bus.wdata[0];
			dt_rst1_o <= bus.wdata[1];
		end
	end

	always_ff @(posedge clk120mhz) begin
		if (do_read) begin
			rdata_q <= rd_word;
		end
	end

	assign bus.rdata = rdata_q;

endmodule

`default_nettype wire

//--- soc_top.sv
// soc backbone top level
// reset sequencing, the PerInt interconnect, the RAM and the
// device table behind one external bus master
`timescale 1ns/1ps
`default_nettype none

module soc_top (
	 input wire clk120mhz
	,input wire rst_p
	,input wire soc_pkg::op_t m_op_i
	,input wire soc_pkg::waddr_t m_addr_i
	,input wire soc_pkg::word_t m_data_i
	,input wire soc_pkg::bsel_t m_sel_i
	,output wire soc_pkg::word_t m_data_o
	,output wire m_rdy_o
	,output wire sys_rst_o
);

	wire dt_rst0;
	wire dt_rst1;

	pi1_if ram_bus ();
	pi1_if dt_bus ();

	reset_ctrl u_reset_ctrl (
		 .clk120mhz (clk120mhz)
		,.rst_p     (rst_p)
		,.dt_rst0_i (dt_rst0)
		,.dt_rst1_i (dt_rst1)
		,.sys_rst_o (sys_rst_o)
	);

	pi1_xbar u_xbar (
		 .clk120mhz (clk120mhz)
		,.sys_rst_i (sys_rst_o)
		,.m_op_i    (m_op_i)
		,.m_addr_i  (m_addr_i)
		,.m_data_i  (m_data_i)
		,.m_sel_i   (m_sel_i)
		,.m_data_o  (m_data_o)
		,.m_rdy_o   (m_rdy_o)
		,.ram_bus   (ram_bus)
		,.dt_bus    (dt_bus)
	);

	ram_slave #(
		.RAM_WORDS (soc_pkg::RAM_MAPSZ)
	) u_ram (
		 .clk120mhz (clk120mhz)
		,.sys_rst_i (sys_rst_o)
		,.bus       (ram_bus)
	);

	dev_table u_dev_table (
		 .clk120mhz (clk120mhz)
		,.sys_rst_i (sys_rst_o)
		,.bus       (dt_bus)
		,.dt_rst0_o (dt_rst0)
		,.dt_rst1_o (dt_rst1)
	);

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
// testbench clock and board reset
// 4 ns clock, reset held for the first 4 cycles and while requested
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
	 input wire rst_req_i
	,output logic clk120mhz
	,output wire rst_p
);

	logic por = 1'b1;

	initial begin
		clk120mhz = 1'b0;
		forever #2 clk120mhz = ~clk120mhz;
	end

	// power-on reset drops on a falling edge
	initial begin
		repeat (4) @(posedge clk120mhz);
		@(negedge clk120mhz);
		por = 1'b0;
	end

	assign rst_p = por | rst_req_i;

endmodule

`default_nettype wire

//--- tb_soc_assert.sv
// bus and reset assertions for the soc top level
// ready stays low in reset, reset follows rst_p, requests hold while stalled
`timescale 1ns/1ps
`default_nettype none

module tb_soc_assert (
	 input wire clk120mhz
	,input wire rst_p
	,input wire soc_pkg::op_t m_op_i
	,input wire m_rdy_o
	,input wire sys_rst_o
);

	a_no_rdy_in_reset: assert property (@(posedge clk120mhz) sys_rst_o |-> !m_rdy_o)
		else $error("m_rdy_o high while sys_rst_o is high");

	a_rst_follows_rst_p: assert property (@(posedge clk120mhz) rst_p |=> sys_rst_o)
		else $error("sys_rst_o did not rise one cycle after rst_p");

	// a stalled request keeps its op
	a_op_held: assert property (@(posedge clk120mhz)
		(m_op_i != soc_pkg::OP_NOOP) && !m_rdy_o |=> $stable(m_op_i))
		else $error("m_op_i changed while the request was stalled");

endmodule

bind soc_top tb_soc_assert u_assert (
	 .clk120mhz (clk120mhz)
	,.rst_p     (rst_p)
	,.m_op_i    (m_op_i)
	,.m_rdy_o   (m_rdy_o)
	,.sys_rst_o (sys_rst_o)
);

`default_nettype wire

//--- tb_soc.sv
// testbench for the soc backbone
// directed tests of reset release, RAM, swap, device table and software reset
`timescale 1ns/1ps
`default_nettype none

module tb_soc;

	// all tests together take well under 600 cycles
	localparam int CYCLE_LIMIT = 4000;
	localparam int N_RAM = 32;

	wire clk120mhz;
	wire rst_p;
	wire soc_pkg::word_t m_data_o;
	wire m_rdy_o;
	wire sys_rst_o;
	logic rst_req;
	soc_pkg::op_t m_op_i;
	soc_pkg::waddr_t m_addr_i;
	soc_pkg::word_t m_data_i;
	soc_pkg::bsel_t m_sel_i;

	int error_cnt;
	int check_cnt;
	int cycle_cnt = 0;
	integer seed;
	soc_pkg::word_t ram_model [soc_pkg::RAM_MAPSZ];
	int used_addr [$];

	tb_clk_gen u_clk_gen (
		 .rst_req_i (rst_req)
		,.clk120mhz (clk120mhz)
		,.rst_p     (rst_p)
	);

	soc_top DUT (
		 .clk120mhz (clk120mhz)
		,.rst_p     (rst_p)
		,.m_op_i    (m_op_i)
		,.m_addr_i  (m_addr_i)
		,.m_data_i  (m_data_i)
		,.m_sel_i   (m_sel_i)
		,.m_data_o  (m_data_o)
		,.m_rdy_o   (m_rdy_o)
		,.sys_rst_o (sys_rst_o)
	);

	always @(posedge clk120mhz) begin
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display(">>> FAIL");
			$finish;
		end else begin
			cycle_cnt <= cycle_cnt + 1;
		end
	end

	task automatic check_eq(input string name, input soc_pkg::word_t exp,
			input soc_pkg::word_t act);
		check_cnt++;
		if (exp !== act) begin
			error_cnt++;
			$display("ERR %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	// called on a falling edge, returns on the falling edge after acceptance
	task automatic bus_access(input soc_pkg::op_t op, input soc_pkg::waddr_t addr,
			input soc_pkg::word_t data, input soc_pkg::bsel_t sel,
			output soc_pkg::word_t rdata);
		int waited;
		waited = 0;
		m_op_i = op;
		m_addr_i = addr;
		m_data_i = data;
		m_sel_i = sel;
		while (!m_rdy_o && waited < 50) begin
			@(negedge clk120mhz);
			waited++;
		end
		if (!m_rdy_o) begin
			error_cnt++;
			$display("bus request to word %h was never accepted", addr);
		end
		@(negedge clk120mhz);
		rdata = m_data_o;
		m_op_i = soc_pkg::OP_NOOP;
	endtask

	task automatic bus_read(input soc_pkg::waddr_t addr, output soc_pkg::word_t data);
		bus_access(soc_pkg::OP_READ, addr, '0, '0, data);
	endtask

	// the model keeps only the selected bytes
	task automatic ram_write(input int a, input soc_pkg::word_t data,
			input soc_pkg::bsel_t sel);
		soc_pkg::word_t unused;
		bus_access(soc_pkg::OP_WRITE, soc_pkg::waddr_t'(a), data, sel, unused);
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) begin
				ram_model[a][8*b +: 8] = data[8*b +: 8];
			end
		end
	endtask

	task automatic wait_release(input string name, input int limit, output int cycles);
		cycles = 0;
		while (sys_rst_o && cycles < limit) begin
			@(negedge clk120mhz);
			cycles++;
		end
		if (sys_rst_o) begin
			error_cnt++;
			$display("%s: system reset still held after %0d cycles", name, limit);
		end
	endtask

	task automatic test_reset_release();
		int cycles;
		int rdy_wrong;
		cycles = 0;
		rdy_wrong = 0;
		wait (rst_p === 1'b1);
		@(negedge rst_p);
		while (sys_rst_o && cycles < 40) begin
			@(negedge clk120mhz);
			cycles++;
			if (m_rdy_o === sys_rst_o) begin
				rdy_wrong++;
			end
		end
		check_eq("reset_release cycles", 15, cycles);
		check_eq("reset_release rdy", 0, rdy_wrong);
	endtask

	task automatic test_ram();
		soc_pkg::word_t r;
		soc_pkg::word_t data;
		int a;
		for (int i = 0; i < N_RAM; i++) begin
			r = $random(seed);
			a = int'(r % soc_pkg::RAM_MAPSZ);
			data = $random(seed);
			ram_write(a, data, 4'hf);
			used_addr.push_back(a);
		end
		foreach (used_addr[i]) begin
			bus_read(soc_pkg::waddr_t'(used_addr[i]), r);
			check_eq("ram readback", ram_model[used_addr[i]], r);
		end
		// partial writes over words that already hold known data
		for (int i = 0; i < 16; i++) begin
			a = used_addr[i];
			data = $random(seed);
			r = $random(seed);
			ram_write(a, data, r[3:0]);
			bus_read(soc_pkg::waddr_t'(a), r);
			check_eq("ram byte select", ram_model[a], r);
		end
	endtask

	task automatic test_swap();
		soc_pkg::word_t old_word;
		soc_pkg::word_t new_word;
		soc_pkg::word_t r;
		int a;
		a = used_addr[0];
		old_word = ram_model[a];
		new_word = $random(seed);
		bus_access(soc_pkg::OP_SWAP, soc_pkg::waddr_t'(a), new_word, 4'hf, r);
		ram_model[a] = new_word;
		check_eq("swap old word", old_word, r);
		bus_read(soc_pkg::waddr_t'(a), r);
		check_eq("swap new word", new_word, r);
	endtask

	task automatic test_dev_table();
		soc_pkg::word_t exp_id [3];
		soc_pkg::word_t exp_sz [3];
		soc_pkg::waddr_t far_addr [4];
		soc_pkg::waddr_t base;
		soc_pkg::word_t r;
		exp_id[soc_pkg::S_RAM] = soc_pkg::DEV_ID_RAM;
		exp_id[soc_pkg::S_DEVTBL] = soc_pkg::DEV_ID_DEVTBL;
		exp_id[soc_pkg::S_INVALID] = soc_pkg::DEV_ID_INVALID;
		exp_sz[soc_pkg::S_RAM] = soc_pkg::RAM_MAPSZ;
		exp_sz[soc_pkg::S_DEVTBL] = soc_pkg::DEVTBL_MAPSZ;
		exp_sz[soc_pkg::S_INVALID] = soc_pkg::INVALID_MAPSZ;
		base = soc_pkg::waddr_t'(soc_pkg::DEVTBL_BASE);
		bus_read(base, r);
		check_eq("devtbl slave count", 3, r);
		for (int k = 0; k < 3; k++) begin
			bus_read(base + soc_pkg::waddr_t'(2 + 2 * k), r);
			check_eq("devtbl device id", exp_id[k], r);
			bus_read(base + soc_pkg::waddr_t'(3 + 2 * k), r);
			check_eq("devtbl map size", exp_sz[k], r);
		end
		far_addr[0] = base + soc_pkg::waddr_t'(soc_pkg::DEVTBL_MAPSZ);
		far_addr[1] = far_addr[0] + soc_pkg::waddr_t'(1);
		far_addr[2] = soc_pkg::waddr_t'(32'h0000_2000);
		far_addr[3] = '1;
		bus_access(soc_pkg::OP_WRITE, far_addr[0], 32'hdead_beef, 4'hf, r);
		foreach (far_addr[i]) begin
			bus_read(far_addr[i], r);
			check_eq("default slave read", 0, r);
		end
	endtask

	task automatic test_soft_reset();
		soc_pkg::waddr_t ctrl;
		soc_pkg::word_t r;
		int cycles;
		int held;
		ctrl = soc_pkg::waddr_t'(soc_pkg::DEVTBL_BASE + 1);
		// warm reset
		bus_access(soc_pkg::OP_WRITE, ctrl, 32'd2, 4'hf, r);
		cycles = 0;
		while (!sys_rst_o && cycles < 2) begin
			@(negedge clk120mhz);
			cycles++;
		end
		check_eq("warm reset raise", 1, soc_pkg::word_t'(sys_rst_o));
		wait_release("warm reset", 40, cycles);
		bus_read(ctrl, r);
		check_eq("warm reset ctrl word", 0, r);
		foreach (used_addr[i]) begin
			bus_read(soc_pkg::waddr_t'(used_addr[i]), r);
			check_eq("warm reset ram kept", ram_model[used_addr[i]], r);
		end
		// power-off holds until rst_p
		bus_access(soc_pkg::OP_WRITE, ctrl, 32'd1, 4'hf, r);
		@(negedge clk120mhz);
		held = 0;
		repeat (100) begin
			@(negedge clk120mhz);
			if (sys_rst_o) begin
				held++;
			end
		end
		check_eq("power off hold", 100, held);
		rst_req = 1'b1;
		repeat (2) @(negedge clk120mhz);
		rst_req = 1'b0;
		// issued while still in reset, so the request stalls until ready
		bus_read(ctrl, r);
		check_eq("power off ctrl word", 0, r);
	endtask

	initial begin
		seed = 32'h6c5f_f58f;
		error_cnt = 0;
		check_cnt = 0;
		rst_req = 1'b0;
		m_op_i = soc_pkg::OP_NOOP;
		m_addr_i = '0;
		m_data_i = '0;
		m_sel_i = '0;
		test_reset_release();
		test_ram();
		test_swap();
		test_dev_table();
		test_soft_reset();
		$display("tests done: %0d checks, %0d errors", check_cnt, error_cnt);
		if (error_cnt == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
soc_pkg.sv
pi1_if.sv
reset_ctrl.sv
pi1_xbar.sv
ram_slave.sv
dev_table.sv
soc_top.sv
tb_clk_gen.sv
tb_soc_assert.sv
tb_soc.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the soc testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f filelist.f --top-module tb_soc -o tb_soc_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_soc_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx ">>> PASS" "$LOG"; then
	exit 0
fi

echo "pass line not found in $LOG"
exit 1
